//--- sim/fdd_tests.txt
# Columns: op addr data expect, all hex, unused columns are 0.
# mount takes the image size in data and the read-only flag in expect.
mount 0 0 0
# Adapter registers.
write 3ffc 1 0
read 3ffc 0 1
write 3ffd 87 0
read 3ffd 0 83
read 3ffe 0 ff
nodev 3ffc 0 ff
# Restore from track 5, then seek to track 12.
write 3ff9 5 0
write 3ff8 0 0
wait_intrq 0 0 0
read 3fff 0 bf
stat1 3ff8 0 84
read 3fff 0 ff
read 3ff9 0 0
write 3ffb c 0
write 3ff8 10 0
wait_intrq 0 0 0
stat1 3ff8 0 80
read 3ff9 0 c
# Read sector with no image.
write 3ffd 80 0
write 3ffa 1 0
write 3ff8 80 0
wait_intrq 0 0 0
stat2 3ff8 0 90
# Image present but drive bit 0 set.
mount 0 5a000 0
write 3ffd 81 0
write 3ff8 80 0
wait_intrq 0 0 0
stat2 3ff8 0 90
# Sector numbers 0 and 10.
write 3ffd 80 0
write 3ffc 0 0
write 3ffa 0 0
write 3ff8 80 0
wait_intrq 0 0 0
stat2 3ff8 0 10
write 3ffa a 0
write 3ff8 80 0
wait_intrq 0 0 0
stat2 3ff8 0 10
# Single-sided image, track 3 sector 4.
write 3ff9 3 0
write 3ffa 4 0
write 3ff8 80 0
read_sector_check 0 0 1e
stat2 3ff8 0 0
# Double-sided image, track 2 side 1 sector 9.
mount 0 b4000 0
write 3ffc 1 0
write 3ff9 2 0
write 3ffa 9 0
write 3ff8 80 0
read_sector_check 0 0 35
stat2 3ff8 0 0
read 3ffa 0 9

//--- compile.f
source/fdd_pkg.sv
source/bus_pkg.sv
source/sector_buffer.sv
source/sd_request.sv
source/wd_core.sv
source/vy0010.sv
source/fdd_top.sv
sim/fdd_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the floppy adapter testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module fdd_tb -f compile.f

out=$(./obj_dir/Vfdd_tb)
echo "$out"
echo "$out" | grep -qx "TESTS PASSED"

//--- sim/fdd_tb.sv
module fdd_tb;

timeunit 1ns;
timeprecision 1ps;

logic        cpu_bus = 1'b0;
logic        reset;
logic        clk_en;
logic [3:0]  dev_typ;
logic [1:0]  dev_num;
logic [13:0] addr;
logic [7:0]  wr_data;
logic        rd;
logic        wr;
logic        img_mounted;
logic [31:0] img_size;
logic        img_readonly;
logic        sd_ack;
logic [8:0]  sd_buff_addr;
logic [7:0]  sd_buff_data;
logic        sd_buff_wr;
logic [7:0]  data;
logic        output_rq;
logic [31:0] sd_lba;
logic        sd_rd;

integer seed = 32'hddab_39ad;
int mismatches = 0;
int failures = 0;

fdd_top #(.step_cycles(8)) DUT (.*);

always #10 cpu_bus = ~cpu_bus;

// ==================================================
// Compare tasks
// ==================================================

task automatic report_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
   $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act);
   mismatches++;
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
   if (act !== exp)
      report_mismatch(name, exp, act);
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
   if (act !== exp)
      report_mismatch(name, exp, act);
endtask

task automatic check_lba(input string name, input logic [31:0] exp, input logic [31:0] act);
   if (act !== exp)
      report_mismatch(name, exp, act);
endtask

// Fields are read through the view of the command that ran last.
task automatic check_status(input fdd_pkg::fdc_status_u exp, input fdd_pkg::fdc_status_u act,
                            input logic type2);
   if (act.t1.not_ready !== exp.t1.not_ready)
      report_mismatch("status.not_ready", exp.t1.not_ready, act.t1.not_ready);
   if (act.t1.busy !== exp.t1.busy)
      report_mismatch("status.busy", exp.t1.busy, act.t1.busy);
   if (type2) begin
      if (act.t2.record_not_found !== exp.t2.record_not_found)
         report_mismatch("status.t2.record_not_found", exp.t2.record_not_found,
                         act.t2.record_not_found);
      if (act.t2.drq !== exp.t2.drq)
         report_mismatch("status.t2.drq", exp.t2.drq, act.t2.drq);
   end else begin
      if (act.t1.seek_error !== exp.t1.seek_error)
         report_mismatch("status.t1.seek_error", exp.t1.seek_error, act.t1.seek_error);
      if (act.t1.track0 !== exp.t1.track0)
         report_mismatch("status.t1.track0", exp.t1.track0, act.t1.track0);
   end
endtask

// ==================================================
// Bus and card stimulus
// ==================================================

task automatic bus_write(input logic [13:0] a, input logic [7:0] d);
   @(posedge cpu_bus);
   addr    <= a;
   wr_data <= d;
   wr      <= 1'b1;
   @(posedge cpu_bus);
   wr <= 1'b0;
endtask

// Read data is combinational, so it is sampled mid cycle.
task automatic bus_read(input logic [13:0] a, input logic [1:0] num,
                        output logic [7:0] d, output logic q);
   @(posedge cpu_bus);
   addr    <= a;
   dev_num <= num;
   rd      <= 1'b1;
   @(negedge cpu_bus);
   d = data;
   q = output_rq;
   @(posedge cpu_bus);
   rd      <= 1'b0;
   dev_num <= 2'd0;
endtask

task automatic mount_image(input logic [31:0] size, input logic ro);
   @(posedge cpu_bus);
   img_size     <= size;
   img_readonly <= ro;
   img_mounted  <= 1'b1;
   @(posedge cpu_bus);
   img_mounted <= 1'b0;
endtask

// Polls the adapter status byte until an active low bit drops.
task automatic wait_status_low(input int pos, input string what);
   logic [7:0] d;
   logic q;
   int cycles;
   cycles = 0;
   bus_read(bus_pkg::addr_status, 2'd0, d, q);
   while (d[pos] !== 1'b0 && cycles < 2000) begin
      bus_read(bus_pkg::addr_status, 2'd0, d, q);
      cycles += 2;
   end
   if (d[pos] !== 1'b0) begin
      $display("Timed out waiting for %s to be set", what);
      failures++;
   end
endtask

// Card model. Byte i of a block is the low LBA byte xor i.
task automatic sd_card_transfer(output logic ok);
   int cycles;
   int delay;
   cycles = 0;
   ok = 1'b0;
   @(negedge cpu_bus);
   while (sd_rd !== 1'b1 && cycles < 2000) begin
      @(negedge cpu_bus);
      cycles++;
   end
   if (sd_rd !== 1'b1) begin
      $display("Timed out waiting for the SD block request");
      failures++;
   end else begin
      ok = 1'b1;
      delay = ($unsigned($random(seed)) % 16) + 1;
      repeat (delay) @(posedge cpu_bus);
      // The request is held until the card answers.
      check_flag("sd_rd", 1'b1, sd_rd);
      for (int i = 0; i < 512; i++) begin
         @(posedge cpu_bus);
         sd_ack       <= 1'b1;
         sd_buff_wr   <= 1'b1;
         sd_buff_addr <= 9'(i);
         sd_buff_data <= sd_lba[7:0] ^ 8'(i);
      end
      @(posedge cpu_bus);
      sd_ack     <= 1'b0;
      sd_buff_wr <= 1'b0;
      check_flag("sd_rd", 1'b0, sd_rd);
   end
endtask

task automatic read_sector_check(input logic [31:0] exp_lba);
   logic [7:0] d;
   logic q;
   logic ok;
   sd_card_transfer(ok);
   if (ok) begin
      check_lba("sd_lba", exp_lba, sd_lba);
      wait_status_low(7, "drq");
      for (int i = 0; i < 512; i++) begin
         bus_read(bus_pkg::addr_wd_base + 14'd3, 2'd0, d, q);
         check_byte($sformatf("data[%0d]", i), exp_lba[7:0] ^ 8'(i), d);
         // Halfway through, drq is still up.
         if (i == 255) begin
            bus_read(bus_pkg::addr_status, 2'd0, d, q);
            check_byte("status", 8'h7F, d);
         end
      end
      bus_read(bus_pkg::addr_status, 2'd0, d, q);
      check_byte("status", 8'hBF, d);
   end
endtask

task automatic run_step(input logic [8*20-1:0] op, input logic [31:0] a,
                        input logic [31:0] d, input logic [31:0] e);
   logic [7:0] rdata;
   logic rq;
   if (op == "mount") begin
      mount_image(d, e[0]);
   end else if (op == "write") begin
      bus_write(a[13:0], d[7:0]);
   end else if (op == "read" || op == "nodev") begin
      bus_read(a[13:0], (op == "nodev") ? 2'd1 : 2'd0, rdata, rq);
      check_flag("output_rq", op == "read", rq);
      check_byte($sformatf("data@%h", a[13:0]), e[7:0], rdata);
   end else if (op == "stat1" || op == "stat2") begin
      bus_read(a[13:0], 2'd0, rdata, rq);
      check_status(e[7:0], rdata, op == "stat2");
   end else if (op == "wait_intrq") begin
      wait_status_low(6, "intrq");
   end else if (op == "read_sector_check") begin
      read_sector_check(e);
   end else begin
      $display("Unknown operation in the test file");
      failures++;
   end
endtask

// ==================================================
// Test file runner
// ==================================================

initial begin
   logic [8*20-1:0] op;
   logic [8*120-1:0] rest;
   logic [31:0] a;
   logic [31:0] d;
   logic [31:0] e;
   int fd;
   int n;
   reset        = 1'b1;
   clk_en       = 1'b1;
   dev_typ      = bus_pkg::dev_vy0010;
   dev_num      = 2'd0;
   addr         = 14'd0;
   wr_data      = 8'd0;
   rd           = 1'b0;
   wr           = 1'b0;
   img_mounted  = 1'b0;
   img_size     = 32'd0;
   img_readonly = 1'b0;
   sd_ack       = 1'b0;
   sd_buff_addr = 9'd0;
   sd_buff_data = 8'd0;
   sd_buff_wr   = 1'b0;
   repeat (10) @(posedge cpu_bus);
   reset <= 1'b0;
   fd = $fopen("sim/fdd_tests.txt", "r");
   if (fd == 0) begin
      $display("Could not open the test file sim/fdd_tests.txt");
      failures++;
   end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
         if (op == "#") begin
            n = $fgets(rest, fd);
         end else begin
            n = $fscanf(fd, "%h %h %h", a, d, e);
            if (n == 3) begin
               run_step(op, a, d, e);
            end else begin
               $display("Test file line is missing a column");
               failures++;
            end
         end
      end
      $fclose(fd);
   end
   $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
   if (mismatches == 0 && failures == 0)
      $display("TESTS PASSED");
   else
      $display("TESTS FAILED");
   $finish;
end

endmodule

//--- source/fdd_top.sv
module fdd_top #(
   parameter int step_cycles = 8
) (
   input  logic        cpu_bus,
   input  logic        reset,
   input  logic        clk_en,
   input  logic [3:0]  dev_typ,
   input  logic [1:0]  dev_num,
   input  logic [13:0] addr,
   input  logic [7:0]  wr_data,
   input  logic        rd,
   input  logic        wr,
   input  logic        img_mounted,
   input  logic [31:0] img_size,
   input  logic        img_readonly,
   input  logic        sd_ack,
   input  logic [8:0]  sd_buff_addr,
   input  logic [7:0]  sd_buff_data,
   input  logic        sd_buff_wr,
   output logic [7:0]  data,
   output logic        output_rq,
   output logic [31:0] sd_lba,
   output logic        sd_rd
);

logic wd_sel;
logic ready;
logic side;
logic layout;
logic write_protect;
logic [7:0] wd_data;
logic drq;
logic intrq;
logic start;
logic done;
logic [7:0] track;
logic [7:0] sector;
logic [8:0] rd_addr;
logic [7:0] rd_byte;

vy0010 adapter (
   .cpu_bus(cpu_bus), .reset(reset), .dev_typ(dev_typ), .dev_num(dev_num),
   .addr(addr), .wr_data(wr_data), .rd(rd), .wr(wr),
   .img_mounted(img_mounted), .img_size(img_size), .img_readonly(img_readonly),
   .wd_data(wd_data), .drq(drq), .intrq(intrq),
   .data(data), .output_rq(output_rq), .wd_sel(wd_sel), .ready(ready),
   .side(side), .layout(layout), .write_protect(write_protect)
);

wd_core #(.step_cycles(step_cycles)) fdc (
   .cpu_bus(cpu_bus), .reset(reset), .clk_en(clk_en), .wd_sel(wd_sel),
   .reg_addr(addr[1:0]), .rd(rd), .wr(wr), .wr_data(wr_data),
   .ready(ready), .side(side), .layout(layout), .write_protect(write_protect),
   .done(done), .rd_byte(rd_byte),
   .wd_data(wd_data), .drq(drq), .intrq(intrq), .start(start),
   .track(track), .sector(sector), .rd_addr(rd_addr)
);

sd_request sd_req (
   .cpu_bus(cpu_bus), .reset(reset), .start(start), .track(track),
   .sector(sector), .side(side), .layout(layout), .sd_ack(sd_ack),
   .sd_lba(sd_lba), .sd_rd(sd_rd), .done(done)
);

sector_buffer buffer (
   .cpu_bus(cpu_bus), .sd_buff_addr(sd_buff_addr), .sd_buff_data(sd_buff_data),
   .sd_buff_wr(sd_buff_wr), .rd_addr(rd_addr), .rd_byte(rd_byte)
);

endmodule

//--- source/vy0010.sv
module vy0010 (
   input  logic        cpu_bus,
   input  logic        reset,
   input  logic [3:0]  dev_typ,
   input  logic [1:0]  dev_num,
   input  logic [13:0] addr,
   input  logic [7:0]  wr_data,
   input  logic        rd,
   input  logic        wr,
   input  logic        img_mounted,
   input  logic [31:0] img_size,
   input  logic        img_readonly,
   input  logic [7:0]  wd_data,
   input  logic        drq,
   input  logic        intrq,
   output logic [7:0]  data,
   output logic        output_rq,
   output logic        wd_sel,
   output logic        ready,
   output logic        side,
   output logic        layout,
   output logic        write_protect
);

logic dev_hit;
logic win;
logic side_sel;
logic drive_sel;
logic status_sel;
logic [7:0] side_reg;
logic [7:0] drive_reg;
logic mounted = 1'b0;

// ==================================================
// Address decode
// ==================================================

assign dev_hit    = (dev_typ == bus_pkg::dev_vy0010) && (dev_num == bus_pkg::dev_num_vy0010);
assign win        = dev_hit && (addr[13:4] == bus_pkg::addr_wd_base[13:4]);
assign wd_sel     = win && (addr[3:2] == 2'd2);
assign side_sel   = dev_hit && (addr == bus_pkg::addr_side);
assign drive_sel  = dev_hit && (addr == bus_pkg::addr_drive);
assign status_sel = dev_hit && (addr == bus_pkg::addr_status);

always_ff @(posedge cpu_bus) begin
   if (reset) begin
      side_reg  <= 8'd0;
      drive_reg <= 8'd0;
   end else if (wr) begin
      if (side_sel)
         side_reg <= wr_data;
      if (drive_sel)
         drive_reg <= wr_data;
   end
end

// Image state follows the mount strobe only.
always_ff @(posedge cpu_bus) begin
   if (img_mounted) begin
      mounted       <= (img_size != 32'd0);
      layout        <= (img_size <= {12'd0, fdd_pkg::single_side_limit});
      write_protect <= img_readonly;
   end
end

assign side  = side_reg[0];
assign ready = mounted & drive_reg[7] & ~drive_reg[0];

// Read mux. Status bits are active low.
// The unused address reads as 0xFF.
always_comb begin
   output_rq = win & rd;
   data      = 8'hFF;
   if (status_sel)
      data = {~drq, ~intrq, 6'b111111};
   else if (side_sel)
      data = side_reg;
   else if (drive_sel)
      data = drive_reg & 8'hFB;
   else if (wd_sel)
      data = wd_data;
end

a_rd_wr_exclusive: assert property (@(posedge cpu_bus) disable iff (reset) !(rd && wr));

endmodule

//--- source/wd_core.sv
module wd_core #(
   parameter int step_cycles = 8
) (
   input  logic       cpu_bus,
   input  logic       reset,
   input  logic       clk_en,
   input  logic       wd_sel,
   input  logic [1:0] reg_addr,
   input  logic       rd,
   input  logic       wr,
   input  logic [7:0] wr_data,
   input  logic       ready,
   input  logic       side,
   input  logic       layout,
   input  logic       write_protect,
   input  logic       done,
   input  logic [7:0] rd_byte,
   output logic [7:0] wd_data,
   output logic       drq,
   output logic       intrq,
   output logic       start,
   output logic [7:0] track,
   output logic [7:0] sector,
   output logic [8:0] rd_addr
);

localparam int cnt_w = (step_cycles > 1) ? $clog2(step_cycles) : 1;
localparam logic [1:0] st_idle = 2'd0;
localparam logic [1:0] st_step = 2'd1;
localparam logic [1:0] st_wait = 2'd2;
localparam logic [1:0] st_xfer = 2'd3;

logic [1:0] state;
fdd_pkg::fdc_status_u status;
logic [7:0] data_reg;
logic [7:0] seek_target;
logic [7:0] next_track;
logic [cnt_w-1:0] step_cnt;
logic [8:0] byte_idx;
logic [3:0] cmd;
logic cmd_wr;
logic data_rd;
logic status_rd;
logic step_end;
logic sector_ok;

assign cmd       = wr_data[7:4];
assign cmd_wr    = wd_sel & wr & (reg_addr == 2'd0) & (state == st_idle);
assign data_rd   = wd_sel & rd & (reg_addr == 2'd3);
assign status_rd = wd_sel & rd & (reg_addr == 2'd0);
assign step_end  = clk_en & (step_cnt == cnt_w'(step_cycles - 1));

// Side 1 does not exist on a single-sided image.
assign sector_ok = (sector >= 8'd1) && (sector <= 8'(fdd_pkg::sectors_per_track))
                   && !(layout && side);
assign start = cmd_wr & (cmd == fdd_pkg::cmd_read_sector) & ready & sector_ok;

assign next_track = (track < seek_target) ? track + 8'd1 :
                    (track > seek_target) ? track - 8'd1 : track;

assign drq     = status.t2.drq;
assign rd_addr = byte_idx;

always_comb begin
   case (reg_addr)
      2'd0:    wd_data = status;
      2'd1:    wd_data = track;
      2'd2:    wd_data = sector;
      default: wd_data = (state == st_xfer) ? rd_byte : data_reg;
   endcase
end

always_ff @(posedge cpu_bus) begin
   if (wd_sel && wr && reg_addr == 2'd3)
      data_reg <= wr_data;
   if (cmd_wr)
      seek_target <= (cmd == fdd_pkg::cmd_seek) ? data_reg : 8'd0;
end

// ==================================================
// Command FSM
// ==================================================

always_ff @(posedge cpu_bus) begin
   if (reset) begin
      state    <= st_idle;
      status   <= '0;
      track    <= 8'd0;
      sector   <= 8'd0;
      intrq    <= 1'b0;
      byte_idx <= 9'd0;
      step_cnt <= '0;
   end else begin
      if (status_rd)
         intrq <= 1'b0;
      if (wd_sel && wr && state == st_idle) begin
         if (reg_addr == 2'd1)
            track <= wr_data;
         if (reg_addr == 2'd2)
            sector <= wr_data;
      end
      if (cmd_wr) begin
         intrq    <= 1'b0;
         step_cnt <= '0;
         if (cmd == fdd_pkg::cmd_restore || cmd == fdd_pkg::cmd_seek) begin
            state     <= st_step;
            status.t1 <= '{not_ready: ~ready, write_protect: write_protect,
                           head_loaded: 1'b0, seek_error: 1'b0, crc_error: 1'b0,
                           track0: (track == 8'd0), index: 1'b0, busy: 1'b1};
         end else if (cmd == fdd_pkg::cmd_read_sector) begin
            status.t2 <= '{not_ready: ~ready, write_protect: write_protect,
                           record_type: 1'b0, record_not_found: ready & ~sector_ok,
                           crc_error: 1'b0, lost_data: 1'b0, drq: 1'b0, busy: start};
            if (start)
               state <= st_wait;
            else
               intrq <= 1'b1;
            // Not ready also flags the record as missing.
            if (!ready)
               status.t2.record_not_found <= 1'b1;
         end
      end
      case (state)
         st_step: begin
            if (step_end) begin
               step_cnt <= '0;
               track    <= next_track;
               if (next_track == seek_target) begin
                  state               <= st_idle;
                  status.t1.busy      <= 1'b0;
                  status.t1.track0    <= (next_track == 8'd0);
                  status.t1.not_ready <= ~ready;
                  intrq               <= 1'b1;
               end
            end else if (clk_en) begin
               step_cnt <= step_cnt + 1'b1;
            end
         end
         st_wait: begin
            if (done) begin
               state         <= st_xfer;
               status.t2.drq <= 1'b1;
               byte_idx      <= 9'd0;
            end
         end
         st_xfer: begin
            if (data_rd) begin
               if (byte_idx == 9'(fdd_pkg::sector_bytes - 1)) begin
                  state          <= st_idle;
                  status.t2.drq  <= 1'b0;
                  status.t2.busy <= 1'b0;
                  intrq          <= 1'b1;
               end else begin
                  byte_idx <= byte_idx + 9'd1;
               end
            end
         end
         default: ;
      endcase
   end
end

a_drq_busy: assert property (@(posedge cpu_bus) disable iff (reset)
   drq |-> status.t2.busy);

// A finished block only arrives while the core waits for it.
a_done_in_wait: assert property (@(posedge cpu_bus) disable iff (reset)
   done |-> (state == st_wait));

endmodule

//--- source/sd_request.sv
module sd_request (
   input  logic        cpu_bus,
   input  logic        reset,
   input  logic        start,
   input  logic [7:0]  track,
   input  logic [7:0]  sector,
   input  logic        side,
   input  logic        layout,
   input  logic        sd_ack,
   output logic [31:0] sd_lba,
   output logic        sd_rd,
   output logic        done
);

logic [31:0] cyl;
logic ack_q;

// Double-sided images interleave the sides per track.
assign cyl = layout ? {24'd0, track} : {23'd0, track, side};

always_ff @(posedge cpu_bus) begin
   if (start)
      sd_lba <= cyl * 32'(fdd_pkg::sectors_per_track) + {24'd0, sector} - 32'd1;
end

always_ff @(posedge cpu_bus) begin
   if (reset) begin
      sd_rd <= 1'b0;
      ack_q <= 1'b0;
   end else begin
      ack_q <= sd_ack;
      if (start)
         sd_rd <= 1'b1;
      else if (sd_ack)
         sd_rd <= 1'b0;
   end
end

// Transfer ends on the falling ack.
assign done = ack_q & ~sd_ack;

// The card only answers an open request.
a_ack_after_rd: assert property (@(posedge cpu_bus) disable iff (reset)
   $rose(sd_ack) |-> sd_rd);

endmodule

//--- source/sector_buffer.sv
module sector_buffer (
   input  logic       cpu_bus,
   input  logic [8:0] sd_buff_addr,
   input  logic [7:0] sd_buff_data,
   input  logic       sd_buff_wr,
   input  logic [8:0] rd_addr,
   output logic [7:0] rd_byte
);

logic [7:0] mem [fdd_pkg::sector_bytes];

// Filled by the card, one byte per strobe.
always_ff @(posedge cpu_bus) begin
   if (sd_buff_wr)
      mem[sd_buff_addr] <= sd_buff_data;
end

// Read is asynchronous so the CPU sees the byte in the same cycle.
assign rd_byte = mem[rd_addr];

endmodule

//--- source/bus_pkg.sv
package bus_pkg;

// Device select on the CPU bus.
localparam logic [3:0] dev_vy0010     = 4'd5;
localparam logic [1:0] dev_num_vy0010 = 2'd0;

// ==================================================
// Adapter window
// ==================================================

// Controller registers sit at base to base + 3.
localparam logic [13:0] addr_wd_base = 14'h3FF8;
localparam logic [13:0] addr_side    = 14'h3FFC;
localparam logic [13:0] addr_drive   = 14'h3FFD;
localparam logic [13:0] addr_unused  = 14'h3FFE;
localparam logic [13:0] addr_status  = 14'h3FFF;

endpackage

//--- source/fdd_pkg.sv
package fdd_pkg;

// ==================================================
// Controller commands
// ==================================================

// Upper nibble of the command byte.
localparam logic [3:0] cmd_restore     = 4'h0;
localparam logic [3:0] cmd_seek        = 4'h1;
localparam logic [3:0] cmd_read_sector = 4'h8;

// ==================================================
// Disk geometry
// ==================================================

localparam int sector_bytes      = 512;
localparam int sectors_per_track = 9;

// Images up to this size hold one side only.
localparam logic [19:0] single_side_limit = 20'h5A000;

// Status byte, read as Type I or Type II depending on the last command.
typedef union packed {
   struct packed {
      logic not_ready;
      logic write_protect;
      logic head_loaded;
      logic seek_error;
      logic crc_error;
      logic track0;
      logic index;
      logic busy;
   } t1;
   struct packed {
      logic not_ready;
      logic write_protect;
      logic record_type;
      logic record_not_found;
      logic crc_error;
      logic lost_data;
      logic drq;
      logic busy;
   } t2;
} fdc_status_u;

endpackage
